// ==== bench/hello_world_assertions.sv ====
// Bound AXI4-Lite handshake and reset assertions for the hello world top level
module hello_world_assertions
  import hello_world_pkg::*;
(
  input logic       clk_main_a0,
  input logic       rst_main_n_sync,
  input logic       awvalid,
  input logic       awready,
  input logic       bvalid,
  input axil_resp_t bresp,
  input logic       bready,
  input logic       rvalid,
  input axil_data_t rdata,
  input logic       rready
);

  timeunit 1ns;
  timeprecision 100ps;

  // Open from aw transfer to b transfer
  logic write_open;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      write_open <= 1'b0;
    end else if (awvalid && awready) begin
      write_open <= 1'b1;
    end else if (bvalid && bready) begin
      write_open <= 1'b0;
    end
  end

  // ----------------------------------------
  // Handshake properties
  // ----------------------------------------

  b_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (bvalid && !bready) |=> (bvalid && $stable(bresp)))
    else $error("write response changed while bready was low");

  r_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (rvalid && !rready) |=> (rvalid && $stable(rdata)))
    else $error("read response changed while rready was low");

  // No second address while a write is in flight
  aw_blocked: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    write_open |-> !awready)
    else $error("awready high before the b transfer");

  // Responses cleared by reset
  reset_clear: assert property (@(posedge clk_main_a0)
    !rst_main_n_sync |=> (!bvalid && !rvalid))
    else $error("response valid in the cycle after reset");

endmodule

bind hello_world_top hello_world_assertions u_hello_world_assertions (
  .clk_main_a0     (clk_main_a0),
  .rst_main_n_sync (rst_main_n_sync),
  .awvalid         (awvalid),
  .awready         (awready),
  .bvalid          (bvalid),
  .bresp           (bresp),
  .bready          (bready),
  .rvalid          (rvalid),
  .rdata           (rdata),
  .rready          (rready)
);

// ==== bench/tb_hello_world.sv ====
// Testbench with clock, reset, random AXI4-Lite traffic, DIP stimulus, reference model and checks
module tb_hello_world
  import hello_world_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  // Every wait loop gives up after this many cycles
  localparam int TIMEOUT_CYCLES = 64;
  localparam int NUM_TRANSACTIONS = 300;

  logic       clk_main_a0;
  logic       rst_main_n_sync;
  logic       awvalid;
  axil_addr_t awaddr;
  logic       awready;
  logic       wvalid;
  axil_data_t wdata;
  axil_strb_t wstrb;
  logic       wready;
  logic       bvalid;
  axil_resp_t bresp;
  logic       bready;
  logic       arvalid;
  axil_addr_t araddr;
  logic       arready;
  logic       rvalid;
  axil_data_t rdata;
  axil_resp_t rresp;
  logic       rready;
  led_t       vdip;
  led_t       vled_status;

  // Random state and reference model
  int         seed = 32'hee59;
  axil_data_t model_hello;
  int         cycle_count;
  int         write_cycle;
  int         vdip_cycle;
  int         led_checks;

  hello_world_top UUT (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wstrb           (wstrb),
    .wready          (wready),
    .bvalid          (bvalid),
    .bresp           (bresp),
    .bready          (bready),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rresp           (rresp),
    .rready          (rready),
    .vdip            (vdip),
    .vled_status     (vled_status)
  );

  // 4 ns clock
  initial begin
    clk_main_a0 = 1'b0;
    forever #2 clk_main_a0 = ~clk_main_a0;
  end

  // Rising edges seen so far, for settle windows
  always @(posedge clk_main_a0) begin
    cycle_count <= cycle_count + 1;
  end

  // ----------------------------------------
  // Reporting
  // ----------------------------------------

  task automatic abort_run();
    $display("test failed");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("error: time %0t, signal %s, expected %h, actual %h",
               $time, name, expected, actual);
      abort_run();
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout: %s did not happen within %0d cycles", what, TIMEOUT_CYCLES);
    abort_run();
  endtask

  // ----------------------------------------
  // Model
  // ----------------------------------------

  function automatic int rand_below(input int unsigned n);
    rand_below = int'($unsigned($random(seed)) % n);
  endfunction

  // Lowest byte ends up in the top lane
  function automatic axil_data_t byte_reverse(input axil_data_t word);
    axil_data_t result;
    for (int i = 0; i < 4; i++) begin
      result[8*i +: 8] = word[8*(3-i) +: 8];
    end
    byte_reverse = result;
  endfunction

  function automatic axil_data_t expected_read(input axil_addr_t addr);
    if (addr == HELLO_WORLD_REG_ADDR) begin
      expected_read = byte_reverse(model_hello);
    end else if (addr == VLED_REG_ADDR) begin
      expected_read = {16'h0000, model_hello[15:0]};
    end else begin
      expected_read = UNIMPLEMENTED_REG_VALUE;
    end
  endfunction

  // Mapped registers twice as likely as unmapped ones
  function automatic axil_addr_t pick_address();
    axil_addr_t addr;
    int         sel;
    sel = rand_below(3);
    if (sel == 0) begin
      addr = HELLO_WORLD_REG_ADDR;
    end else if (sel == 1) begin
      addr = VLED_REG_ADDR;
    end else begin
      do begin
        addr = $random(seed);
      end while (addr == HELLO_WORLD_REG_ADDR || addr == VLED_REG_ADDR);
    end
    pick_address = addr;
  endfunction

  // ----------------------------------------
  // Bus transactions
  // ----------------------------------------

  task automatic axi_write(input axil_addr_t addr, input axil_data_t data);
    int waited;
    int stall;
    stall = rand_below(6);
    @(negedge clk_main_a0);
    awvalid = 1'b1;
    awaddr  = addr;
    #1;
    waited = 0;
    while (awready !== 1'b1) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) report_timeout("awready high");
      @(negedge clk_main_a0);
      #1;
    end
    // aw transfer on the coming edge
    @(negedge clk_main_a0);
    awvalid = 1'b0;
    wvalid  = 1'b1;
    wdata   = data;
    wstrb   = axil_strb_t'($random(seed));
    #1;
    waited = 0;
    while (wready !== 1'b1) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) report_timeout("wready high");
      @(negedge clk_main_a0);
      #1;
    end
    write_cycle = cycle_count;
    if (addr == HELLO_WORLD_REG_ADDR) begin
      model_hello = data;
    end
    @(negedge clk_main_a0);
    wvalid = 1'b0;
    #1;
    waited = 0;
    while (bvalid !== 1'b1) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) report_timeout("bvalid high");
      @(negedge clk_main_a0);
      #1;
    end
    check_value("bresp", 32'(RESP_OKAY), 32'(bresp));
    // Response must sit still while bready is low
    repeat (stall) begin
      @(negedge clk_main_a0);
      #1;
      check_value("bvalid", 32'd1, 32'(bvalid));
      check_value("bresp", 32'(RESP_OKAY), 32'(bresp));
    end
    @(negedge clk_main_a0);
    bready = 1'b1;
    #1;
    check_value("bvalid", 32'd1, 32'(bvalid));
    @(negedge clk_main_a0);
    bready = 1'b0;
    #1;
    // Exactly one b transfer per write
    check_value("bvalid", 32'd0, 32'(bvalid));
  endtask

  task automatic axi_read(input axil_addr_t addr);
    axil_data_t expected;
    int         waited;
    int         stall;
    expected = expected_read(addr);
    stall    = rand_below(6);
    @(negedge clk_main_a0);
    arvalid = 1'b1;
    araddr  = addr;
    #1;
    waited = 0;
    while (arready !== 1'b1) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) report_timeout("arready high");
      @(negedge clk_main_a0);
      #1;
    end
    @(negedge clk_main_a0);
    arvalid = 1'b0;
    #1;
    waited = 0;
    while (rvalid !== 1'b1) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) report_timeout("rvalid high");
      @(negedge clk_main_a0);
      #1;
    end
    check_value("rdata", expected, rdata);
    check_value("rresp", 32'(RESP_OKAY), 32'(rresp));
    // Stalled read keeps its data
    repeat (stall) begin
      @(negedge clk_main_a0);
      #1;
      check_value("rvalid", 32'd1, 32'(rvalid));
      check_value("rdata", expected, rdata);
    end
    @(negedge clk_main_a0);
    rready = 1'b1;
    #1;
    check_value("rdata", expected, rdata);
    @(negedge clk_main_a0);
    rready = 1'b0;
    #1;
    check_value("rvalid", 32'd0, 32'(rvalid));
    check_value("arready", 32'd1, 32'(arready));
  endtask

  // ----------------------------------------
  // LED status
  // ----------------------------------------

  task automatic change_dip();
    @(negedge clk_main_a0);
    vdip       = led_t'($random(seed));
    vdip_cycle = cycle_count;
  endtask

  // Only once switches and shadow have settled
  task automatic check_led_status();
    if ((cycle_count - vdip_cycle >= 4) && (cycle_count - write_cycle >= 3)) begin
      check_value("vled_status", 32'(model_hello[15:0] & vdip), 32'(vled_status));
      led_checks++;
    end
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------

  initial begin
    axil_addr_t addr;
    int         idle;
    rst_main_n_sync = 1'b0;
    awvalid     = 1'b0;
    awaddr      = '0;
    wvalid      = 1'b0;
    wdata       = '0;
    wstrb       = '0;
    bready      = 1'b0;
    arvalid     = 1'b0;
    araddr      = '0;
    rready      = 1'b0;
    vdip        = '0;
    model_hello = '0;
    cycle_count = 0;
    write_cycle = 0;
    vdip_cycle  = 0;
    led_checks  = 0;
    repeat (5) @(negedge clk_main_a0);
    rst_main_n_sync = 1'b1;
    #1;
    check_value("bvalid", 32'd0, 32'(bvalid));
    check_value("rvalid", 32'd0, 32'(rvalid));
    check_value("vled_status", 32'd0, 32'(vled_status));
    check_value("awready", 32'd1, 32'(awready));
    check_value("arready", 32'd1, 32'(arready));
    // Directed register map walk
    axi_read(HELLO_WORLD_REG_ADDR);
    axi_write(HELLO_WORLD_REG_ADDR, 32'h1234_5678);
    axi_read(HELLO_WORLD_REG_ADDR);
    axi_read(VLED_REG_ADDR);
    axi_write(32'h0000_0600, 32'hffff_ffff);
    axi_read(32'h0000_0600);
    axi_read(HELLO_WORLD_REG_ADDR);
    axi_read(VLED_REG_ADDR);
    // Random traffic
    for (int n = 0; n < NUM_TRANSACTIONS; n++) begin
      if (rand_below(4) == 0) begin
        change_dip();
      end
      addr = pick_address();
      if (rand_below(2) == 0) begin
        axi_write(addr, $random(seed));
      end else begin
        axi_read(addr);
      end
      idle = rand_below(5);
      repeat (idle) begin
        @(negedge clk_main_a0);
        #1;
      end
      check_led_status();
    end
    if (led_checks == 0) begin
      $display("vled_status was never checked in a settled window");
      abort_run();
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

// ==== common/hello_world_pkg.sv ====
// Bus, LED and write FSM types plus the register map of the hello world peripheral
package hello_world_pkg;

  // ----------------------------------------
  // Register bus types
  // ----------------------------------------

  // Byte address on the AXI4-Lite bus
  typedef logic [31:0] axil_addr_t;

  // One register word
  typedef logic [31:0] axil_data_t;

  // Byte lane strobes, carried but not acted on
  typedef logic [3:0] axil_strb_t;

  // B and R response code
  typedef logic [1:0] axil_resp_t;

  // One bit per virtual LED or DIP switch
  typedef logic [15:0] led_t;

  // Single-beat write handshake states
  typedef enum logic [1:0] {
    WR_IDLE = 2'd0,
    WR_DATA = 2'd1,
    WR_RESP = 2'd2
  } wr_state_t;

  // ----------------------------------------
  // Register map
  // ----------------------------------------

  // Read back byte-swapped
  localparam axil_addr_t HELLO_WORLD_REG_ADDR = 32'h0000_0500;

  // Read-only LED shadow
  localparam axil_addr_t VLED_REG_ADDR = 32'h0000_0504;

  // Returned for every unmapped address
  localparam axil_data_t UNIMPLEMENTED_REG_VALUE = 32'hdead_dead;

  // Only response ever given
  localparam axil_resp_t RESP_OKAY = 2'b00;

endpackage

// ==== rtl/axil_reg_slave.sv ====
// Single-beat AXI4-Lite slave producing register write strobes and read lookups
module axil_reg_slave
  import hello_world_pkg::*;
(
  input  logic       clk_main_a0,
  input  logic       rst_main_n_sync,
  // Write address channel
  input  logic       awvalid,
  input  axil_addr_t awaddr,
  output logic       awready,
  // Write data channel
  input  logic       wvalid,
  input  axil_data_t wdata,
  // Byte strobes come with the bus, every write is full word
  input  axil_strb_t wstrb,
  output logic       wready,
  // Write response channel
  output logic       bvalid,
  output axil_resp_t bresp,
  input  logic       bready,
  // Read address channel
  input  logic       arvalid,
  input  axil_addr_t araddr,
  output logic       arready,
  // Read data channel
  output logic       rvalid,
  output axil_data_t rdata,
  output axil_resp_t rresp,
  input  logic       rready,
  // Register block side
  output logic       wr_en,
  output axil_addr_t wr_addr,
  output axil_data_t wr_data,
  output axil_addr_t rd_addr,
  input  axil_data_t rd_data
);

  wr_state_t  wr_state;
  wr_state_t  wr_state_nxt;
  axil_addr_t awaddr_q;
  axil_addr_t araddr_q;
  logic       aw_fire;
  logic       w_fire;
  logic       ar_fire;
  logic       ar_pending;

  // ----------------------------------------
  // Write side
  // ----------------------------------------

  // Address only taken while idle
  assign awready = (wr_state == WR_IDLE);
  assign aw_fire = awvalid && awready;

  // Data accepted as soon as it shows up in WR_DATA
  assign w_fire = (wr_state == WR_DATA) && wvalid;
  assign wready = w_fire;

  // Response pending is exactly the WR_RESP state
  assign bvalid = (wr_state == WR_RESP);
  assign bresp  = RESP_OKAY;

  always_comb begin
    wr_state_nxt = wr_state;
    unique case (wr_state)
      WR_IDLE: begin
        if (awvalid) begin
          wr_state_nxt = WR_DATA;
        end
      end
      WR_DATA: begin
        if (wvalid) begin
          wr_state_nxt = WR_RESP;
        end
      end
      WR_RESP: begin
        // Stalls here for as long as bready is low
        if (bready) begin
          wr_state_nxt = WR_IDLE;
        end
      end
      default: wr_state_nxt = WR_IDLE;
    endcase
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_state <= WR_IDLE;
    end else begin
      wr_state <= wr_state_nxt;
    end
  end

  // Write address held until the data beat
  always_ff @(posedge clk_main_a0) begin
    if (aw_fire) begin
      awaddr_q <= awaddr;
    end
  end

  // Strobe lasts only the w transfer cycle
  assign wr_en   = w_fire;
  assign wr_addr = awaddr_q;
  assign wr_data = wdata;

  // ----------------------------------------
  // Read side
  // ----------------------------------------

  // Blocked from acceptance until the response is taken
  assign arready = !ar_pending && !rvalid;
  assign ar_fire = arvalid && arready;
  assign rresp   = RESP_OKAY;

  always_ff @(posedge clk_main_a0) begin
    if (ar_fire) begin
      araddr_q <= araddr;
    end
  end

  // Register block decodes this, lookup is combinational
  assign rd_addr = araddr_q;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      ar_pending <= 1'b0;
      rvalid     <= 1'b0;
      rdata      <= '0;
    end else begin
      // Pending for one cycle while the lookup settles
      ar_pending <= ar_fire;
      if (rvalid && rready) begin
        rvalid <= 1'b0;
        rdata  <= '0;
      end else if (ar_pending) begin
        rvalid <= 1'b1;
        rdata  <= rd_data;
      end
    end
  end

endmodule

// ==== rtl/hello_world_regs.sv ====
// Hello world register, LED shadow register and read data mux
module hello_world_regs
  import hello_world_pkg::*;
(
  input  logic       clk_main_a0,
  input  logic       rst_main_n_sync,
  input  logic       wr_en,
  input  axil_addr_t wr_addr,
  input  axil_data_t wr_data,
  input  axil_addr_t rd_addr,
  output axil_data_t rd_data,
  output led_t       vled
);

  axil_data_t hello_world_q;
  axil_data_t hello_world_swapped;
  led_t       vled_q;

  // ----------------------------------------
  // Hello world register
  // ----------------------------------------

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      hello_world_q <= '0;
    end else if (wr_en && (wr_addr == HELLO_WORLD_REG_ADDR)) begin
      hello_world_q <= wr_data;
    end
  end

  // Byte 0 comes back in the top lane
  assign hello_world_swapped = {hello_world_q[7:0], hello_world_q[15:8],
                                hello_world_q[23:16], hello_world_q[31:24]};

  // ----------------------------------------
  // LED shadow
  // ----------------------------------------

  // Trails the low half by one cycle, not bus writable
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vled_q <= '0;
    end else begin
      vled_q <= hello_world_q[15:0];
    end
  end

  assign vled = vled_q;

  // Read lookup, sampled by the slave
  always_comb begin
    unique case (rd_addr)
      HELLO_WORLD_REG_ADDR: rd_data = hello_world_swapped;
      VLED_REG_ADDR:        rd_data = {16'h0000, vled_q};
      default:              rd_data = UNIMPLEMENTED_REG_VALUE;
    endcase
  end

endmodule

// ==== rtl/hello_world_top.sv ====
// Top level joining the AXI4-Lite slave, register block and LED status block
module hello_world_top
  import hello_world_pkg::*;
(
  input  logic       clk_main_a0,
  input  logic       rst_main_n_sync,
  // AXI4-Lite from the host
  input  logic       awvalid,
  input  axil_addr_t awaddr,
  output logic       awready,
  input  logic       wvalid,
  input  axil_data_t wdata,
  input  axil_strb_t wstrb,
  output logic       wready,
  output logic       bvalid,
  output axil_resp_t bresp,
  input  logic       bready,
  input  logic       arvalid,
  input  axil_addr_t araddr,
  output logic       arready,
  output logic       rvalid,
  output axil_data_t rdata,
  output axil_resp_t rresp,
  input  logic       rready,
  // Virtual DIP switches and LEDs
  input  led_t       vdip,
  output led_t       vled_status
);

  // Slave to register block
  logic       wr_en;
  axil_addr_t wr_addr;
  axil_data_t wr_data;
  axil_addr_t rd_addr;
  axil_data_t rd_data;
  // Register block to LED block
  led_t       vled;

  // ----------------------------------------
  // Bus slave
  // ----------------------------------------
  axil_reg_slave u_axil_reg_slave (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wstrb           (wstrb),
    .wready          (wready),
    .bvalid          (bvalid),
    .bresp           (bresp),
    .bready          (bready),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rresp           (rresp),
    .rready          (rready),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data)
  );

  // ----------------------------------------
  // Registers and LED status
  // ----------------------------------------
  hello_world_regs u_hello_world_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data),
    .vled            (vled)
  );

  vled_status u_vled_status (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .vled            (vled),
    .vdip            (vdip),
    .vled_status     (vled_status)
  );

endmodule

// ==== rtl/vled_status.sv ====
// DIP switch synchroniser, LED masking and registered LED status output
module vled_status
  import hello_world_pkg::*;
(
  input  logic clk_main_a0,
  input  logic rst_main_n_sync,
  // Shadow LEDs from the register block
  input  led_t vled,
  // Asynchronous switches from outside
  input  led_t vdip,
  output led_t vled_status
);

  led_t vdip_q;
  led_t vdip_q2;
  led_t vled_masked;

  // ----------------------------------------
  // DIP switch synchroniser
  // ----------------------------------------

  // Two flops before any logic sees the switches
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vdip_q  <= '0;
      vdip_q2 <= '0;
    end else begin
      vdip_q  <= vdip;
      vdip_q2 <= vdip_q;
    end
  end

  // ----------------------------------------
  // Status output
  // ----------------------------------------

  // LED lit only where its switch is on
  assign vled_masked = vled & vdip_q2;

  // Output flop, third stage after the switches
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vled_status <= '0;
    end else begin
      vled_status <= vled_masked;
    end
  end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build the hello world testbench with Verilator and run it.
# The exit status is the simulator's: non-zero on any failure.

cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --timescale 1ns/100ps \
    -f src.f --top-module tb_hello_world -o tb_hello_world &&
  ./obj_dir/tb_hello_world ||
  { echo "simulation run did not succeed"; exit 1; }

// ==== src.f ====
common/hello_world_pkg.sv
rtl/axil_reg_slave.sv
rtl/hello_world_regs.sv
rtl/vled_status.sv
rtl/hello_world_top.sv
bench/hello_world_assertions.sv
bench/tb_hello_world.sv
